//--- src/soc_pkg.sv
package soc_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // top nibble of the byte address picks the target
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  localparam logic [REGION_MSB-REGION_LSB:0] REGION_SRAM = 4'h0;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_IO   = 4'hC;

  // word offsets inside the io region
  localparam logic [1:0] IO_LED_OFS   = 2'd0;
  localparam logic [1:0] IO_KEY_OFS   = 2'd1;
  localparam logic [1:0] IO_PRESS_OFS = 2'd2;

  typedef struct packed {
    logic              stb;    // one request per high cycle
    logic              we;
    logic [SEL_W-1:0]  sel;    // byte selects
    logic [ADDR_W-1:0] addr;   // byte address
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              ack;    // one cycle after stb
    logic              err;    // unmapped only
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

//--- src/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic              clk,
  input  logic              rst_n_i,

  input  soc_pkg::bus_req_t bus_req_i,
  output soc_pkg::bus_rsp_t bus_rsp_o,

  output soc_pkg::bus_req_t sram_req_o,
  input  soc_pkg::bus_rsp_t sram_rsp_i,

  output soc_pkg::bus_req_t io_req_o,
  input  soc_pkg::bus_rsp_t io_rsp_i
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_SRAM,
    TGT_IO,
    TGT_ERR
  } target_e;

  logic [REGION_MSB-REGION_LSB:0] region;
  logic                           hit_sram;
  logic                           hit_io;
  target_e                        tgt_d;
  target_e                        tgt_q;

  assign region   = bus_req_i.addr[REGION_MSB:REGION_LSB];
  assign hit_sram = (region == REGION_SRAM);
  assign hit_io   = (region == REGION_IO);

  // payload fans out to both, only the strobe is steered
  always_comb
  begin
    sram_req_o     = bus_req_i;
    sram_req_o.stb = bus_req_i.stb & hit_sram;
    io_req_o       = bus_req_i;
    io_req_o.stb   = bus_req_i.stb & hit_io;
  end

  always_comb
  begin
    tgt_d = TGT_NONE;
    if (bus_req_i.stb)
    begin
      if (hit_sram)
        tgt_d = TGT_SRAM;
      else if (hit_io)
        tgt_d = TGT_IO;
      else
        tgt_d = TGT_ERR;   // nobody else will ack this one
    end
  end

  // who owes a response in the next cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      tgt_q <= TGT_NONE;
    else
      tgt_q <= tgt_d;
  end

  always_comb
  begin
    case (tgt_q)
      TGT_SRAM:
      begin
        bus_rsp_o = sram_rsp_i;
      end
      TGT_IO:
      begin
        bus_rsp_o = io_rsp_i;
      end
      TGT_ERR:
      begin
        bus_rsp_o.ack   = 1'b1;
        bus_rsp_o.err   = 1'b1;
        bus_rsp_o.rdata = '0;
      end
      default:
      begin
        bus_rsp_o = '0;   // idle
      end
    endcase
  end

endmodule

//--- src/sram_slave.sv
`timescale 1ns/1ps

module sram_slave #(
  parameter int SRAM_AW = 10
) (
  input  logic              clk,
  input  logic              rst_n_i,

  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  import soc_pkg::*;

  localparam int DEPTH = 2 ** SRAM_AW;

  logic [DATA_W-1:0]  mem [DEPTH];
  logic [SRAM_AW-1:0] word_idx;
  logic               ack_q;
  logic [DATA_W-1:0]  rdata_q;

  // upper address bits inside the region alias onto the same words
  assign word_idx = req_i.addr[SRAM_AW+1:2];

  always_ff @(posedge clk)
  begin
    if (req_i.stb && req_i.we)
    begin
      for (int b = 0; b < SEL_W; b++)
      begin
        if (req_i.sel[b])
          mem[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
      end
    end
  end

  // old word, a same-cycle write lands after
  always_ff @(posedge clk)
  begin
    if (req_i.stb)
      rdata_q <= mem[word_idx];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i.stb;
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- src/board_io_regs.sv
`timescale 1ns/1ps

module board_io_regs #(
  parameter int LED_W = 8,
  parameter int KEY_W = 2
) (
  input  logic              clk,
  input  logic              rst_n_i,

  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o,

  input  logic [KEY_W-1:0]  key_i,
  output logic [LED_W-1:0]  led_o
);

  import soc_pkg::*;

  logic [1:0]        ofs;
  logic              wr;
  logic [KEY_W-1:0]  wmask;
  logic [LED_W-1:0]  led_q;
  logic [KEY_W-1:0]  key_meta;
  logic [KEY_W-1:0]  key_sync;
  logic [KEY_W-1:0]  key_prev;
  logic [KEY_W-1:0]  key_rise;
  logic [KEY_W-1:0]  press_clr;
  logic [KEY_W-1:0]  press_q;
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;

  assign ofs = req_i.addr[3:2];
  assign wr  = req_i.stb & req_i.we;

  // byte selects spread to a bit mask
  always_comb
  begin
    for (int i = 0; i < KEY_W; i++)
      wmask[i] = req_i.sel[i/8];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      led_q <= '0;
    else if (wr && ofs == IO_LED_OFS && req_i.sel[0])
      led_q <= req_i.wdata[LED_W-1:0];
  end

  assign led_o = led_q;

  // two flops for the async keys, a third for edge detect
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_prev <= '0;
    end
    else
    begin
      key_meta <= key_i;
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  assign key_rise  = key_sync & ~key_prev;
  assign press_clr = (wr && ofs == IO_PRESS_OFS) ?
                     (req_i.wdata[KEY_W-1:0] & wmask) : '0;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      press_q <= '0;
    else
      press_q <= (press_q & ~press_clr) | key_rise;   // set wins
  end

  always_comb
  begin
    rdata_d = '0;
    case (ofs)
      IO_LED_OFS:   rdata_d[LED_W-1:0] = led_q;
      IO_KEY_OFS:   rdata_d[KEY_W-1:0] = key_sync;
      IO_PRESS_OFS: rdata_d[KEY_W-1:0] = press_q;
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (req_i.stb)
      rdata_q <= rdata_d;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i.stb;
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- src/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
  parameter int SRAM_AW = 10,
  parameter int LED_W   = 8,
  parameter int KEY_W   = 2
) (
  input  logic              clk,
  input  logic              rst_n_i,

  input  soc_pkg::bus_req_t bus_req_i,
  output soc_pkg::bus_rsp_t bus_rsp_o,

  input  logic [KEY_W-1:0]  key_i,
  output logic [LED_W-1:0]  led_o
);

  import soc_pkg::*;

  bus_req_t sram_req;
  bus_rsp_t sram_rsp;
  bus_req_t io_req;
  bus_rsp_t io_rsp;

  bus_decoder i_decoder (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .bus_req_i  (bus_req_i),
    .bus_rsp_o  (bus_rsp_o),
    .sram_req_o (sram_req),
    .sram_rsp_i (sram_rsp),
    .io_req_o   (io_req),
    .io_rsp_i   (io_rsp)
  );

  // region 0x0
  sram_slave #(
    .SRAM_AW (SRAM_AW)
  ) i_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (sram_req),
    .rsp_o   (sram_rsp)
  );

  // region 0xC
  board_io_regs #(
    .LED_W (LED_W),
    .KEY_W (KEY_W)
  ) i_io (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (io_req),
    .rsp_o   (io_rsp),
    .key_i   (key_i),
    .led_o   (led_o)
  );

endmodule

//--- verif/soc_chk.sv
`timescale 1ns/1ps

module soc_chk #(
  parameter int LED_W = 8
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  soc_pkg::bus_req_t req_i,
  input  soc_pkg::bus_rsp_t rsp_i,
  input  logic [LED_W-1:0]  led_i
);

  int fail_cnt = 0;   // read by the testbench

  // every request is answered in the next cycle
  ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_i.stb |=> rsp_i.ack)
  else
  begin
    $error("no ack in the cycle after a request strobe");
    fail_cnt = fail_cnt + 1;
  end

  ack_only_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_i.ack |-> $past(req_i.stb))
  else
  begin
    $error("ack without a request strobe in the cycle before");
    fail_cnt = fail_cnt + 1;
  end

  err_needs_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_i.err |-> rsp_i.ack)
  else
  begin
    $error("err raised without ack");
    fail_cnt = fail_cnt + 1;
  end

  // outputs quiet once a reset edge has been seen
  reset_state: assert property (@(posedge clk)
    !rst_n_i |=> (!rsp_i.ack && !rsp_i.err && led_i == '0))
  else
  begin
    $error("bus response or leds not cleared by reset");
    fail_cnt = fail_cnt + 1;
  end

endmodule

bind soc_top soc_chk #(
  .LED_W (LED_W)
) i_chk (
  .clk     (clk),
  .rst_n_i (rst_n_i),
  .req_i   (bus_req_i),
  .rsp_i   (bus_rsp_o),
  .led_i   (led_o)
);

//--- verif/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

  import soc_pkg::*;

  localparam int SRAM_AW  = 10;
  localparam int LED_W    = 8;
  localparam int KEY_W    = 2;
  localparam int DEPTH    = 2 ** SRAM_AW;
  localparam int TIMEOUT  = 64;
  localparam int KEY_HOLD = 8;
  localparam int N_WORDS  = 16;

  typedef struct packed {
    logic              chk_data;   // compare rdata too
    logic              err;
    logic [DATA_W-1:0] rdata;
  } rsp_expect_t;

  logic             clk;
  logic             rst_n_i;
  bus_req_t         bus_req_i;
  bus_rsp_t         bus_rsp_o;
  logic [KEY_W-1:0] key_i;
  logic [LED_W-1:0] led_o;

  rsp_expect_t       next_exp;
  rsp_expect_t       exp_q [$];
  logic [DATA_W-1:0] sram_model [int unsigned];
  logic [LED_W-1:0]  led_model;
  logic [KEY_W-1:0]  key_model;
  logic [KEY_W-1:0]  press_model;

  soc_top #(
    .SRAM_AW (SRAM_AW),
    .LED_W   (LED_W),
    .KEY_W   (KEY_W)
  ) i_dut (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .key_i     (key_i),
    .led_o     (led_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                   input logic [DATA_W-1:0] data,
                                                   input logic [SEL_W-1:0]  sel);
    logic [DATA_W-1:0] r;
    r = old;
    for (int b = 0; b < SEL_W; b++)
    begin
      if (sel[b])
        r[b*8 +: 8] = data[b*8 +: 8];
    end
    return r;
  endfunction

  // hi_bits land above the word index and must alias
  function automatic logic [ADDR_W-1:0] sram_addr(input int unsigned idx,
                                                 input int unsigned hi_bits);
    logic [ADDR_W-1:0] a;
    a = hi_bits << (SRAM_AW + 2);
    a[SRAM_AW+1:2] = idx[SRAM_AW-1:0];
    a[1:0] = 2'b00;
    a[REGION_MSB:REGION_LSB] = REGION_SRAM;
    return a;
  endfunction

  function automatic logic [DATA_W-1:0] io_expect(input logic [1:0] ofs);
    logic [DATA_W-1:0] r;
    r = '0;
    case (ofs)
      IO_LED_OFS:   r[LED_W-1:0] = led_model;
      IO_KEY_OFS:   r[KEY_W-1:0] = key_model;
      IO_PRESS_OFS: r[KEY_W-1:0] = press_model;
      default:      r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [3:0] pick_bad_region();
    logic [3:0] r;
    r = 4'($urandom % 14) + 4'd1;
    if (r >= REGION_IO)
      r = r + 4'd1;   // skips 0xC
    return r;
  endfunction

  task automatic send(input bus_req_t req, input rsp_expect_t exp);
    bus_req_i = req;
    next_exp  = exp;
    @(negedge clk);
  endtask

  task automatic sram_write(input int unsigned idx, input int unsigned hi_bits,
                            input logic [DATA_W-1:0] data, input logic [SEL_W-1:0] sel);
    bus_req_t          req;
    rsp_expect_t       exp;
    logic [DATA_W-1:0] old;
    req       = '0;
    req.stb   = 1'b1;
    req.we    = 1'b1;
    req.sel   = sel;
    req.addr  = sram_addr(idx, hi_bits);
    req.wdata = data;
    old = sram_model.exists(idx) ? sram_model[idx] : '0;
    sram_model[idx] = merge_bytes(old, data, sel);
    exp = '0;
    send(req, exp);
  endtask

  task automatic sram_read(input int unsigned idx, input int unsigned hi_bits);
    bus_req_t    req;
    rsp_expect_t exp;
    req          = '0;
    req.stb      = 1'b1;
    req.sel      = 4'hF;
    req.addr     = sram_addr(idx, hi_bits);
    exp          = '0;
    exp.chk_data = 1'b1;
    exp.rdata    = sram_model[idx];
    send(req, exp);
  endtask

  task automatic io_write(input logic [1:0] ofs, input logic [DATA_W-1:0] data,
                          input logic [SEL_W-1:0] sel);
    bus_req_t    req;
    rsp_expect_t exp;
    req       = '0;
    req.stb   = 1'b1;
    req.we    = 1'b1;
    req.sel   = sel;
    req.addr  = {REGION_IO, 24'h0, ofs, 2'b00};
    req.wdata = data;
    if (ofs == IO_LED_OFS && sel[0])
      led_model = data[LED_W-1:0];
    if (ofs == IO_PRESS_OFS)
    begin
      for (int i = 0; i < KEY_W; i++)
      begin
        if (data[i] && sel[i/8])
          press_model[i] = 1'b0;   // write 1 to clear
      end
    end
    exp = '0;
    send(req, exp);
  endtask

  task automatic io_read(input logic [1:0] ofs);
    bus_req_t    req;
    rsp_expect_t exp;
    req          = '0;
    req.stb      = 1'b1;
    req.sel      = 4'hF;
    req.addr     = {REGION_IO, 24'h0, ofs, 2'b00};
    exp          = '0;
    exp.chk_data = 1'b1;
    exp.rdata    = io_expect(ofs);
    send(req, exp);
  endtask

  task automatic unmapped_access(input logic [3:0] region, input logic we,
                                 input logic [27:0] low_addr, input logic [DATA_W-1:0] data);
    bus_req_t    req;
    rsp_expect_t exp;
    req          = '0;
    req.stb      = 1'b1;
    req.we       = we;
    req.sel      = 4'hF;
    req.addr     = {region, low_addr[27:2], 2'b00};
    req.wdata    = data;
    exp          = '0;
    exp.chk_data = 1'b1;
    exp.err      = 1'b1;
    send(req, exp);
  endtask

  task automatic check_led();
    assert (led_o == led_model)
    else fail_stop($sformatf("ERROR: led_o got %h expected %h", led_o, led_model));
  endtask

  task automatic drain();
    int n;
    bus_req_i = '0;
    n = 0;
    while (exp_q.size() != 0)
    begin
      if (n == TIMEOUT)
        fail_stop("timed out waiting for outstanding bus responses");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic set_keys(input logic [KEY_W-1:0] val);
    drain();
    press_model = press_model | (val & ~key_model);
    key_model   = val;
    key_i       = val;
    repeat (KEY_HOLD) @(negedge clk);   // past sync and edge delay
  endtask

  always @(posedge clk)
  begin
    if (rst_n_i && bus_req_i.stb)
      exp_q.push_back(next_exp);
  end

  always @(negedge clk)
  begin : response_check
    rsp_expect_t cur;
    if (i_dut.i_chk.fail_cnt != 0)
      fail_stop("a bus timing assertion failed");
    if (rst_n_i && bus_rsp_o.ack)
    begin
      if (exp_q.size() == 0)
        fail_stop("ack arrived with no request outstanding");
      else
      begin
        cur = exp_q.pop_front();
        assert (bus_rsp_o.err == cur.err)
        else fail_stop($sformatf("ERROR: bus_rsp_o.err got %h expected %h",
                                 bus_rsp_o.err, cur.err));
        if (cur.chk_data)
        begin
          assert (bus_rsp_o.rdata == cur.rdata)
          else fail_stop($sformatf("ERROR: bus_rsp_o.rdata got %h expected %h",
                                   bus_rsp_o.rdata, cur.rdata));
        end
      end
    end
  end

  initial
  begin : stimulus
    int unsigned idx_list [N_WORDS];
    int unsigned known_idx;
    void'($urandom(32'hf1bc_86ba));
    rst_n_i     = 1'b0;
    bus_req_i   = '0;
    key_i       = '0;
    next_exp    = '0;
    led_model   = '0;
    key_model   = '0;
    press_model = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    check_led();

    // random words, read back through other alias addresses
    for (int i = 0; i < N_WORDS; i++)
    begin
      idx_list[i] = $urandom % DEPTH;
      sram_write(idx_list[i], $urandom, $urandom, 4'hF);
    end
    for (int i = 0; i < N_WORDS; i++)
      sram_read(idx_list[i], $urandom);
    drain();

    known_idx = DEPTH - 3;
    sram_write(known_idx, 0, 32'h1122_3344, 4'hF);
    sram_write(known_idx, 0, 32'haabb_ccdd, 4'b0101);
    sram_read(known_idx, 0);
    sram_write(known_idx, 0, 32'h5566_7788, 4'b1000);
    sram_read(known_idx, 0);
    drain();

    // back-to-back across both regions
    sram_write(idx_list[0], 0, $urandom, 4'hF);
    io_write(IO_LED_OFS, $urandom, 4'h1);
    check_led();
    sram_read(idx_list[0], 0);
    io_read(IO_LED_OFS);
    sram_write(idx_list[1], $urandom, $urandom, 4'hF);
    io_read(IO_KEY_OFS);
    sram_read(idx_list[1], 0);
    io_write(IO_LED_OFS, $urandom, 4'hE);   // sel[0] clear
    check_led();
    io_read(IO_LED_OFS);
    io_write(2'd3, $urandom, 4'hF);
    io_read(2'd3);
    drain();

    set_keys(2'b01);
    io_read(IO_KEY_OFS);
    io_read(IO_PRESS_OFS);
    set_keys(2'b00);
    io_read(IO_KEY_OFS);
    io_read(IO_PRESS_OFS);
    io_write(IO_PRESS_OFS, 32'h0, 4'hF);
    io_read(IO_PRESS_OFS);
    io_write(IO_PRESS_OFS, 32'h1, 4'hF);
    io_read(IO_PRESS_OFS);
    set_keys(2'b11);
    io_read(IO_PRESS_OFS);
    io_write(IO_PRESS_OFS, 32'h2, 4'hF);
    io_read(IO_PRESS_OFS);
    io_write(IO_KEY_OFS, $urandom, 4'hF);
    io_read(IO_KEY_OFS);
    set_keys(2'b00);

    // low bits hit live sram words, state must not move
    for (int i = 0; i < 8; i++)
    begin
      unmapped_access(pick_bad_region(), 1'($urandom % 2),
                      28'(sram_addr(idx_list[i], 0)), $urandom);
    end
    unmapped_access(4'hF, 1'b1, 28'h0, 32'hffff_ffff);
    for (int i = 0; i < 8; i++)
      sram_read(idx_list[i], 0);
    io_read(IO_LED_OFS);
    check_led();
    drain();

    if (i_dut.i_chk.fail_cnt != 0)
      fail_stop("bus timing assertions failed");
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- filelist.f
src/soc_pkg.sv
src/bus_decoder.sv
src/sram_slave.sv
src/board_io_regs.sv
src/soc_top.sv
verif/soc_chk.sv
verif/soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module soc_tb \
  -f filelist.f --Mdir obj_dir -o soc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/soc_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Test OK'; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
